// File: alu.sv
`timescale 1ns/10ps

module alu (
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [15:0] imm16,
	input mips_pkg::ctrl_t ctrl,
	output logic [31:0] y,
	output logic equal
);

	logic [31:0] imm_ext;
	logic [31:0] op_b;

	always_comb begin
		case (ctrl.ext)
			mips_pkg::ext_zero: imm_ext = {16'h0000, imm16};
			mips_pkg::ext_upper: imm_ext = {imm16, 16'h0000};
			default: imm_ext = {{16{imm16[15]}}, imm16};
		endcase
	end

	assign op_b = ctrl.alu_src_imm ? imm_ext : b;

	always_comb begin
		case (ctrl.alu_op)
			mips_pkg::or_op: y = a | op_b;
			mips_pkg::add_op: y = a + op_b;
			mips_pkg::sub_op: y = a - op_b;
			mips_pkg::lui_op: y = {op_b[31:16], 16'h0000};
			default: y = op_b;
		endcase
	end

	// beq compares the raw register operands
	assign equal = (a == b);

endmodule

// File: control_unit.sv
`timescale 1ns/10ps

module control_unit (
	input logic [31:0] instr,
	output mips_pkg::ctrl_t ctrl
);

	mips_pkg::op_t op;
	mips_pkg::funct_t funct;

	assign op = mips_pkg::op_t'(instr[31:26]);
	assign funct = mips_pkg::funct_t'(instr[5:0]);

	always_comb begin
		// Defaults leave anything unmatched as a no-op
		ctrl = '0;
		ctrl.rs = instr[25:21];
		ctrl.rt = instr[20:16];
		ctrl.imm26 = instr[25:0];
		ctrl.ext = mips_pkg::ext_sign;
		ctrl.alu_op = mips_pkg::pass_b;
		ctrl.wd_src = mips_pkg::wd_alu;

		case (op)
			mips_pkg::op_special: begin
				case (funct)
					mips_pkg::funct_addu: begin
						ctrl.rf_we = 1'b1;
						ctrl.wa = instr[15:11];
						ctrl.alu_op = mips_pkg::add_op;
					end
					mips_pkg::funct_subu: begin
						ctrl.rf_we = 1'b1;
						ctrl.wa = instr[15:11];
						ctrl.alu_op = mips_pkg::sub_op;
					end
					mips_pkg::funct_jr: ctrl.jump_reg = 1'b1;
					default: ;
				endcase
			end
			mips_pkg::op_ori: begin
				ctrl.rf_we = 1'b1;
				ctrl.wa = instr[20:16];
				ctrl.ext = mips_pkg::ext_zero;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = mips_pkg::or_op;
			end
			mips_pkg::op_lui: begin
				ctrl.rf_we = 1'b1;
				ctrl.wa = instr[20:16];
				ctrl.ext = mips_pkg::ext_upper;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = mips_pkg::lui_op;
			end
			mips_pkg::op_lw: begin
				ctrl.rf_we = 1'b1;
				ctrl.wa = instr[20:16];
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = mips_pkg::add_op;
				ctrl.wd_src = mips_pkg::wd_mem;
			end
			mips_pkg::op_sw: begin
				ctrl.dm_we = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = mips_pkg::add_op;
			end
			// Compare happens on the ALU equal flag
			mips_pkg::op_beq: ctrl.branch = 1'b1;
			mips_pkg::op_j: ctrl.jump_imm = 1'b1;
			mips_pkg::op_jal: begin
				ctrl.jump_imm = 1'b1;
				ctrl.rf_we = 1'b1;
				ctrl.wa = mips_pkg::LINK_REG;
				ctrl.wd_src = mips_pkg::wd_link;
			end
			default: ;
		endcase
	end

endmodule

// File: data_mem.sv
`timescale 1ns/10ps

module data_mem (
	input logic clk,
	input logic rst_n,
	input logic we,
	input logic [31:0] addr,
	input logic [31:0] wd,
	output logic [31:0] rd
);

	logic [31:0] mem [mips_pkg::DMEM_WORDS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < mips_pkg::DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[addr[7:2]] <= wd;
		end
	end

	// Word index only so upper address bits wrap
	assign rd = mem[addr[7:2]];

	a_word_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		we |-> (addr[1:0] == 2'b00)
	) else $error("unaligned store to data memory");

endmodule

// File: mips_core.sv
`timescale 1ns/10ps

module mips_core (
	input logic clk,
	input logic rst_n,
	output logic fetch_valid,
	input logic fetch_ready,
	output logic [31:0] fetch_pc,
	input logic [31:0] fetch_instr,
	output logic commit_valid,
	input logic commit_ready,
	output mips_pkg::commit_t commit_data
);

	mips_pkg::core_state_t state;
	logic [31:0] pc;
	logic [31:0] ir;
	mips_pkg::ctrl_t ctrl;
	mips_pkg::commit_t commit_q;
	mips_pkg::commit_t commit_next;

	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] alu_y;
	logic alu_equal;
	logic [31:0] dm_rd;
	logic [31:0] wd;
	logic rf_we;
	logic dm_we;

	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] next_pc;

	//////////////////////////////
	// Datapath
	//////////////////////////////

	control_unit u_ctrl (
		.instr (ir),
		.ctrl  (ctrl)
	);

	reg_file u_rf (
		.clk   (clk),
		.rst_n (rst_n),
		.ra1   (ctrl.rs),
		.ra2   (ctrl.rt),
		.wa    (ctrl.wa),
		.we    (rf_we),
		.wd    (wd),
		.rd1   (rs_data),
		.rd2   (rt_data)
	);

	alu u_alu (
		.a     (rs_data),
		.b     (rt_data),
		.imm16 (ctrl.imm26[15:0]),
		.ctrl  (ctrl),
		.y     (alu_y),
		.equal (alu_equal)
	);

	data_mem u_dm (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (dm_we),
		.addr  (alu_y),
		.wd    (rt_data),
		.rd    (dm_rd)
	);

	// Writes only land at the end of execute
	assign rf_we = ctrl.rf_we && (state == mips_pkg::st_execute);
	assign dm_we = ctrl.dm_we && (state == mips_pkg::st_execute);

	always_comb begin
		case (ctrl.wd_src)
			mips_pkg::wd_mem: wd = dm_rd;
			mips_pkg::wd_link: wd = pc_plus4;
			default: wd = alu_y;
		endcase
	end

	//////////////////////////////
	// Next PC
	//////////////////////////////

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 + {{14{ir[15]}}, ir[15:0], 2'b00};
	assign jump_target = {pc_plus4[31:28], ctrl.imm26, 2'b00};

	always_comb begin
		next_pc = pc_plus4;
		if (ctrl.jump_reg) begin
			next_pc = rs_data;
		end else if (ctrl.jump_imm) begin
			next_pc = jump_target;
		end else if (ctrl.branch && alu_equal) begin
			next_pc = branch_target;
		end
	end

	// Commit record with unused fields zeroed
	always_comb begin
		commit_next = '0;
		commit_next.pc = pc;
		if (ctrl.rf_we) begin
			commit_next.rf_we = 1'b1;
			commit_next.rf_addr = ctrl.wa;
			commit_next.rf_data = wd;
		end
		if (ctrl.dm_we) begin
			commit_next.dm_we = 1'b1;
			commit_next.dm_addr = {26'b0, alu_y[7:2]};
			commit_next.dm_data = rt_data;
		end
	end

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mips_pkg::st_fetch;
			pc <= mips_pkg::RESET_PC;
		end else begin
			case (state)
				mips_pkg::st_fetch: if (fetch_ready) state <= mips_pkg::st_execute;
				mips_pkg::st_execute: begin
					state <= mips_pkg::st_commit;
					pc <= next_pc;
				end
				mips_pkg::st_commit: if (commit_ready) state <= mips_pkg::st_fetch;
				default: state <= mips_pkg::st_fetch;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid && fetch_ready) ir <= fetch_instr;
		if (state == mips_pkg::st_execute) commit_q <= commit_next;
	end

	assign fetch_valid = (state == mips_pkg::st_fetch);
	assign fetch_pc = pc;
	assign commit_valid = (state == mips_pkg::st_commit);
	assign commit_data = commit_q;

	a_commit_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(commit_valid && !commit_ready) |=> (commit_valid && $stable(commit_data))
	) else $error("commit record changed under back-pressure");

	// jr can carry any register value into the PC
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		fetch_valid |-> (fetch_pc[1:0] == 2'b00)
	) else $error("fetch address not word aligned");

endmodule

// File: mips_pkg.sv
package mips_pkg;

	//////////////////////////////
	// Sizes and fixed addresses
	//////////////////////////////

	localparam int DMEM_WORDS = 64;
	localparam logic [4:0] LINK_REG = 5'd31;
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	//////////////////////////////
	// Instruction encodings
	//////////////////////////////

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		op_special = 6'b000000,
		op_j       = 6'b000010,
		op_jal     = 6'b000011,
		op_beq     = 6'b000100,
		op_ori     = 6'b001101,
		op_lui     = 6'b001111,
		op_lw      = 6'b100011,
		op_sw      = 6'b101011
	} op_t;

	// Function field of special, instr[5:0]
	typedef enum logic [5:0] {
		funct_jr   = 6'b001000,
		funct_addu = 6'b100001,
		funct_subu = 6'b100011
	} funct_t;

	//////////////////////////////
	// Datapath selects
	//////////////////////////////

	typedef enum logic [2:0] {
		pass_b = 3'b000,
		or_op  = 3'b001,
		add_op = 3'b010,
		sub_op = 3'b011,
		lui_op = 3'b100
	} alu_op_t;

	typedef enum logic [1:0] {
		ext_sign  = 2'b00,
		ext_zero  = 2'b01,
		ext_upper = 2'b10
	} ext_t;

	typedef enum logic [1:0] {
		wd_alu  = 2'b00,
		wd_mem  = 2'b01,
		wd_link = 2'b10
	} wd_src_t;

	// Decoded instruction
	typedef struct packed {
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  wa;
		logic [25:0] imm26;
		ext_t        ext;
		alu_op_t     alu_op;
		logic        alu_src_imm;
		logic        rf_we;
		logic        dm_we;
		wd_src_t     wd_src;
		logic        branch;
		logic        jump_imm;
		logic        jump_reg;
	} ctrl_t;

	// One retired instruction
	typedef struct packed {
		logic [31:0] pc;
		logic        rf_we;
		logic [4:0]  rf_addr;
		logic [31:0] rf_data;
		logic        dm_we;
		logic [31:0] dm_addr;
		logic [31:0] dm_data;
	} commit_t;

	typedef enum logic [1:0] {
		st_fetch   = 2'b00,
		st_execute = 2'b01,
		st_commit  = 2'b10
	} core_state_t;

endpackage

// File: mips_tests.txt
# I <word address> <instruction>
# C <pc> <rf_we> <rf_addr> <rf_data> <dm_we> <dm_addr> <dm_data>
I 00 34011234
I 01 3C02ABCD
I 02 00221821
I 03 00222023
I 04 AC030008
I 05 8C050008
I 06 34005555
I 07 00013021
I 08 10260001
I 09 3407DEAD
I 0A 10220005
I 0B 0C000010
I 0C 08000014
I 10 00804021
I 11 03E00008
I 14 ACC8FFFC
I 15 8CC9FFFC
I 16 1000FFFF
C 00000000 1 01 00001234 0 00000000 00000000
C 00000004 1 02 abcd0000 0 00000000 00000000
C 00000008 1 03 abcd1234 0 00000000 00000000
C 0000000c 1 04 54331234 0 00000000 00000000
C 00000010 0 00 00000000 1 00000002 abcd1234
C 00000014 1 05 abcd1234 0 00000000 00000000
C 00000018 1 00 00005555 0 00000000 00000000
C 0000001c 1 06 00001234 0 00000000 00000000
C 00000020 0 00 00000000 0 00000000 00000000
C 00000028 0 00 00000000 0 00000000 00000000
C 0000002c 1 1f 00000030 0 00000000 00000000
C 00000040 1 08 54331234 0 00000000 00000000
C 00000044 0 00 00000000 0 00000000 00000000
C 00000030 0 00 00000000 0 00000000 00000000
C 00000050 0 00 00000000 1 0000000c 54331234
C 00000054 1 09 54331234 0 00000000 00000000
C 00000058 0 00 00000000 0 00000000 00000000

// File: reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input logic clk,
	input logic rst_n,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa,
	input logic we,
	input logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// $zero reads as zero whatever was stored there
	assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

	// A written register reads back the stored word
	a_write_readback: assert property (
		@(posedge clk) disable iff (!rst_n)
		(we && wa != 5'd0) |=> (ra1 != $past(wa) || rd1 == $past(wd))
	) else $error("register file read back differs from written word");

endmodule

// File: tb.f
mips_pkg.sv
control_unit.sv
reg_file.sv
alu.sv
data_mem.sv
mips_core.sv
tb_mips_core.sv

// File: tb_mips_core.sv
`timescale 1ns/10ps

module tb_mips_core;

	logic clk;
	logic rst_n;
	logic fetch_valid;
	logic fetch_ready;
	logic [31:0] fetch_pc;
	logic [31:0] fetch_instr;
	logic commit_valid;
	logic commit_ready;
	mips_pkg::commit_t commit_data;

	// Word-addressed program image
	logic [31:0] imem [256];
	mips_pkg::commit_t expected [$];
	logic [31:0] lfsr;
	int n_expected;

	mips_core dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_valid  (fetch_valid),
		.fetch_ready  (fetch_ready),
		.fetch_pc     (fetch_pc),
		.fetch_instr  (fetch_instr),
		.commit_valid (commit_valid),
		.commit_ready (commit_ready),
		.commit_data  (commit_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois form with taps 32 22 2 1
	function automatic logic random_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	//////////////////////////////
	// Environment side of both ports
	//////////////////////////////

	always @(posedge clk) begin
		fetch_ready <= random_bit();
		commit_ready <= random_bit();
		fetch_instr <= imem[fetch_pc[9:2]];
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t: fetch_pc got %h expected %h",
				$time, got, exp));
		end
	endtask

	task automatic check_commit(input mips_pkg::commit_t got, input mips_pkg::commit_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t: commit_data got %h expected %h",
				$time, got, exp));
		end
	endtask

	task automatic load_tests();
		int fd;
		int n;
		string line;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] f [7];
		mips_pkg::commit_t rec;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		fd = $fopen("mips_tests.txt", "r");
		if (fd == 0) abort_run("cannot open mips_tests.txt");
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#") continue;
			if (line[0] == "I") begin
				if ($sscanf(line, "I %h %h", addr, word) != 2)
					abort_run("malformed instruction line in mips_tests.txt");
				imem[addr[7:0]] = word;
			end else if (line[0] == "C") begin
				if ($sscanf(line, "C %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6]) != 7)
					abort_run("malformed commit line in mips_tests.txt");
				rec.pc = f[0];
				rec.rf_we = f[1][0];
				rec.rf_addr = f[2][4:0];
				rec.rf_data = f[3];
				rec.dm_we = f[4][0];
				rec.dm_addr = f[5];
				rec.dm_data = f[6];
				expected.push_back(rec);
			end else begin
				abort_run("unknown line tag in mips_tests.txt");
			end
		end
		$fclose(fd);
		n_expected = expected.size();
	endtask

	// One instruction through its fetch and commit handshakes
	task automatic run_one(input mips_pkg::commit_t exp);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > 200) abort_run("timeout waiting for a fetch handshake");
		end while (!(fetch_valid && fetch_ready));
		check_pc(fetch_pc, exp.pc);
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > 200) abort_run("timeout waiting for a commit handshake");
			// Record must hold while stalled
			if (commit_valid) check_commit(commit_data, exp);
		end while (!(commit_valid && commit_ready));
	endtask

	initial begin
		rst_n = 1'b0;
		fetch_ready = 1'b0;
		commit_ready = 1'b0;
		fetch_instr = '0;
		lfsr = 32'h8d43_7c7f;
		load_tests();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		while (expected.size() > 0) begin
			run_one(expected.pop_front());
		end
		if (n_expected > 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			abort_run("no commit records were checked");
		end
	end

endmodule
